/* logic/pkt_cdc_pkg.sv */
package pkt_cdc_pkg;

	//////////////////////////////
	// Beat geometry
	//////////////////////////////

	// Data bits carried per beat
	localparam int PKT_DW = 32;

	// Byte count field, wide enough to index a byte lane
	localparam int PKT_BW = $clog2(PKT_DW);

	//////////////////////////////
	// Payload types
	//////////////////////////////

	// One beat as the sender hands it over
	typedef struct packed {
		logic [PKT_DW-1:0] data;
		logic [PKT_BW-1:0] bytes;
		// High on the final beat of a packet
		logic              last;
	} pkt_beat_t;

	// One FIFO slot
	// Abort set means this slot is a marker and the beat fields carry no packet data
	typedef struct packed {
		logic      abort;
		pkt_beat_t beat;
	} fifo_entry_t;

	//////////////////////////////
	// Tracker FSM
	//////////////////////////////

	typedef enum logic [1:0] {
		// Between packets
		ST_IDLE,
		// Inside a packet, last beat not yet seen
		ST_MIDPKT,
		// Abort marker held back by a full FIFO
		ST_ABORT_PEND
	} ctrl_state_t;

endpackage

/* logic/pkt_cdc_ram.sv */
`timescale 1ns/1ps

module pkt_cdc_ram #(
	parameter int LGFIFO = 4
) (
	input  logic                     S_CLK,
	// Write port in the sender domain
	input  logic                     i_wr,
	input  logic [LGFIFO-1:0]        i_waddr,
	input  pkt_cdc_pkg::fifo_entry_t i_wentry,
	// Read port, no clock
	input  logic [LGFIFO-1:0]        i_raddr,
	output pkt_cdc_pkg::fifo_entry_t o_rentry
);
	import pkt_cdc_pkg::*;

	// Storage for 2^LGFIFO entries
	fifo_entry_t mem [0:(1<<LGFIFO)-1];

	//////////////////////////////
	// Write port
	//////////////////////////////

	always_ff @(posedge S_CLK) begin
		if (i_wr)
			mem[i_waddr] <= i_wentry;
	end

	//////////////////////////////
	// Read port
	//////////////////////////////

	// Head entry is visible with valid, first word fall through
	assign o_rentry = mem[i_raddr];

endmodule

/* logic/pkt_cdc_wptr.sv */
`timescale 1ns/1ps

module pkt_cdc_wptr #(
	parameter int LGFIFO = 4
) (
	input  logic              S_CLK,
	input  logic              S_ARESETN,
	input  logic              i_wr,
	// Read pointer from the M_CLK domain
	input  logic [LGFIFO:0]   i_rgray,
	output logic [LGFIFO-1:0] o_waddr,
	output logic [LGFIFO:0]   o_wgray,
	output logic              o_full
);

	// One extra bit tells a full FIFO from an empty one
	logic [LGFIFO:0] wbin;
	logic [LGFIFO:0] wbin_next;
	logic [LGFIFO:0] rq1;
	logic [LGFIFO:0] rq2;

	//////////////////////////////
	// Write pointer
	//////////////////////////////

	// Caller only writes when not full
	assign wbin_next = wbin + {{LGFIFO{1'b0}}, i_wr};

	always_ff @(posedge S_CLK) begin
		if (S_ARESETN) begin
			wbin    <= '0;
			o_wgray <= '0;
		end else begin
			wbin    <= wbin_next;
			// Gray copy changes one bit per step for the crossing
			o_wgray <= (wbin_next >> 1) ^ wbin_next;
		end
	end

	assign o_waddr = wbin[LGFIFO-1:0];

	//////////////////////////////
	// Read pointer sync
	//////////////////////////////

	// Two flops into S_CLK
	always_ff @(posedge S_CLK) begin
		if (S_ARESETN) begin
			rq1 <= '0;
			rq2 <= '0;
		end else begin
			rq1 <= i_rgray;
			rq2 <= rq1;
		end
	end

	// Full when a whole lap ahead
	// In Gray code that is the top two bits inverted, rest equal
	assign o_full = (o_wgray == {~rq2[LGFIFO:LGFIFO-1], rq2[LGFIFO-2:0]});

	// Tracker must hold off writes for as long as full is seen
	a_hold_full: assert property (@(posedge S_CLK) disable iff (S_ARESETN)
		o_full |=> (wbin == $past(wbin)));

endmodule

/* logic/pkt_cdc_rptr.sv */
`timescale 1ns/1ps

module pkt_cdc_rptr #(
	parameter int LGFIFO = 4
) (
	input  logic              M_CLK,
	input  logic              M_ARESETN,
	input  logic              i_m_ready,
	// Write pointer from the S_CLK domain
	input  logic [LGFIFO:0]   i_wgray,
	output logic [LGFIFO-1:0] o_raddr,
	output logic [LGFIFO:0]   o_rgray,
	output logic              o_empty
);

	logic [LGFIFO:0] rbin;
	logic [LGFIFO:0] rbin_next;
	logic [LGFIFO:0] wq1;
	logic [LGFIFO:0] wq2;
	logic            pop;

	//////////////////////////////
	// Write pointer sync
	//////////////////////////////

	// Two flops into M_CLK
	always_ff @(posedge M_CLK) begin
		if (M_ARESETN) begin
			wq1 <= '0;
			wq2 <= '0;
		end else begin
			wq1 <= i_wgray;
			wq2 <= wq1;
		end
	end

	// Empty when the read side has caught up
	assign o_empty = (o_rgray == wq2);

	//////////////////////////////
	// Read pointer
	//////////////////////////////

	// Valid is the inverse of empty, so this is the valid/ready transfer
	assign pop       = i_m_ready && !o_empty;
	assign rbin_next = rbin + {{LGFIFO{1'b0}}, pop};

	always_ff @(posedge M_CLK) begin
		if (M_ARESETN) begin
			rbin    <= '0;
			o_rgray <= '0;
		end else begin
			rbin    <= rbin_next;
			o_rgray <= (rbin_next >> 1) ^ rbin_next;
		end
	end

	assign o_raddr = rbin[LGFIFO-1:0];

	// Synchronized write pointer only moves forward
	// So empty can only come back through a pop
	a_empty_on_pop: assert property (@(posedge M_CLK) disable iff (M_ARESETN)
		$rose(o_empty) |-> $past(pop));

endmodule

/* logic/pkt_cdc_ctrl.sv */
`timescale 1ns/1ps

module pkt_cdc_ctrl (
	input  logic                    S_CLK,
	input  logic                    S_ARESETN,
	// Sender handshake
	input  logic                    i_s_valid,
	output logic                    o_s_ready,
	input  pkt_cdc_pkg::pkt_beat_t  i_s_beat,
	input  logic                    i_s_abort,
	// FIFO write side
	input  logic                    i_full,
	output logic                    o_wr,
	output pkt_cdc_pkg::fifo_entry_t o_wr_entry
);
	import pkt_cdc_pkg::*;

	ctrl_state_t state;
	logic        beat_xfer;
	logic        marker;

	//////////////////////////////
	// Sender handshake
	//////////////////////////////

	// Abort is always taken
	// Otherwise stall on full or while a marker still waits
	assign o_s_ready = i_s_abort || (!i_full && (state != ST_ABORT_PEND));

	// A beat that comes with an abort is dropped
	assign beat_xfer = i_s_valid && o_s_ready && !i_s_abort;

	//////////////////////////////
	// Marker generation
	//////////////////////////////

	always_comb begin
		marker = 1'b0;
		case (state)
			// Held marker goes out as soon as a slot frees up
			ST_ABORT_PEND: marker = !i_full;
			// Fresh abort inside a packet, written now if there is room
			ST_MIDPKT:     marker = i_s_abort && !i_full;
			default:       marker = 1'b0;
		endcase
	end

	// Beat writes and marker writes never coincide
	assign o_wr       = beat_xfer || marker;
	assign o_wr_entry = '{abort: marker, beat: i_s_beat};

	//////////////////////////////
	// Packet tracker FSM
	//////////////////////////////

	always_ff @(posedge S_CLK) begin
		if (S_ARESETN) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					// Abort here is accepted and forgotten
					if (beat_xfer && !i_s_beat.last)
						state <= ST_MIDPKT;
				end
				ST_MIDPKT: begin
					if (i_s_abort)
						state <= i_full ? ST_ABORT_PEND : ST_IDLE;
					else if (beat_xfer && i_s_beat.last)
						state <= ST_IDLE;
				end
				ST_ABORT_PEND: begin
					// Marker written this cycle
					if (!i_full)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Full comes from the pointer block and may only rise after one of our writes
	// Read side progress can only make room
	a_full_on_write: assert property (@(posedge S_CLK) disable iff (S_ARESETN)
		$rose(i_full) |-> $past(o_wr));

endmodule

/* logic/pkt_cdc_top.sv */
`timescale 1ns/1ps

module pkt_cdc_top #(
	// log2 of FIFO depth, passed down to pointers and memory
	parameter int LGFIFO = 4
) (
	// Sender side
	input  logic                     S_CLK,
	input  logic                     S_ARESETN,
	input  logic                     i_s_valid,
	output logic                     o_s_ready,
	input  pkt_cdc_pkg::pkt_beat_t   i_s_beat,
	input  logic                     i_s_abort,
	// Receiver side
	input  logic                     M_CLK,
	input  logic                     M_ARESETN,
	output logic                     o_m_valid,
	input  logic                     i_m_ready,
	output pkt_cdc_pkg::fifo_entry_t o_m_entry
);
	import pkt_cdc_pkg::*;

	// Sender domain
	logic              wr;
	fifo_entry_t       wr_entry;
	logic              full;
	logic [LGFIFO-1:0] waddr;
	logic [LGFIFO:0]   wgray;

	// Receiver domain
	logic              empty;
	logic [LGFIFO-1:0] raddr;
	logic [LGFIFO:0]   rgray;

	//////////////////////////////
	// Write side
	//////////////////////////////

	// Packet tracker decides every FIFO write
	pkt_cdc_ctrl i_pkt_cdc_ctrl (
		.S_CLK      (S_CLK),
		.S_ARESETN  (S_ARESETN),
		.i_s_valid  (i_s_valid),
		.o_s_ready  (o_s_ready),
		.i_s_beat   (i_s_beat),
		.i_s_abort  (i_s_abort),
		.i_full     (full),
		.o_wr       (wr),
		.o_wr_entry (wr_entry)
	);

	pkt_cdc_wptr #(.LGFIFO(LGFIFO)) i_pkt_cdc_wptr (
		.S_CLK     (S_CLK),
		.S_ARESETN (S_ARESETN),
		.i_wr      (wr),
		.i_rgray   (rgray),
		.o_waddr   (waddr),
		.o_wgray   (wgray),
		.o_full    (full)
	);

	// Memory spans both domains
	pkt_cdc_ram #(.LGFIFO(LGFIFO)) i_pkt_cdc_ram (
		.S_CLK    (S_CLK),
		.i_wr     (wr),
		.i_waddr  (waddr),
		.i_wentry (wr_entry),
		.i_raddr  (raddr),
		.o_rentry (o_m_entry)
	);

	//////////////////////////////
	// Read side
	//////////////////////////////

	pkt_cdc_rptr #(.LGFIFO(LGFIFO)) i_pkt_cdc_rptr (
		.M_CLK     (M_CLK),
		.M_ARESETN (M_ARESETN),
		.i_m_ready (i_m_ready),
		.i_wgray   (wgray),
		.o_raddr   (raddr),
		.o_rgray   (rgray),
		.o_empty   (empty)
	);

	// Head entry is valid whenever anything is stored
	assign o_m_valid = !empty;

endmodule

/* tb/pkt_cdc_tb.sv */
`timescale 1ns/1ps

module pkt_cdc_tb;
	import pkt_cdc_pkg::*;

	localparam int LGFIFO  = 4;
	localparam int TIMEOUT = 500;

	// One sender command as read from the vectors file
	typedef struct packed {
		logic [7:0]  op;
		logic [31:0] gap;
		// Number of E lines above this command
		logic [31:0] exp_before;
		pkt_beat_t   beat;
	} cmd_t;

	logic        S_CLK;
	logic        S_ARESETN;
	logic        M_CLK;
	logic        M_ARESETN;
	logic        i_s_valid;
	logic        o_s_ready;
	pkt_beat_t   i_s_beat;
	logic        i_s_abort;
	logic        o_m_valid;
	logic        i_m_ready;
	fifo_entry_t o_m_entry;

	cmd_t        cmds[$];
	fifo_entry_t exp_q[$];
	int          pop_count;
	int          mismatches;
	int          other_errors;
	logic        rx_hold;
	// Set by any timeout, stops the command loop
	logic        stalled;

	pkt_cdc_top #(.LGFIFO(LGFIFO)) i_pkt_cdc_top (
		.S_CLK     (S_CLK),
		.S_ARESETN (S_ARESETN),
		.i_s_valid (i_s_valid),
		.o_s_ready (o_s_ready),
		.i_s_beat  (i_s_beat),
		.i_s_abort (i_s_abort),
		.M_CLK     (M_CLK),
		.M_ARESETN (M_ARESETN),
		.o_m_valid (o_m_valid),
		.i_m_ready (i_m_ready),
		.o_m_entry (o_m_entry)
	);

	//////////////////////////////
	// Clocks, receiver reset
	//////////////////////////////

	initial begin
		S_CLK = 1'b0;
		forever #10 S_CLK = ~S_CLK;
	end

	// 26 ns, unrelated to S_CLK
	initial begin
		M_CLK = 1'b0;
		forever #13 M_CLK = ~M_CLK;
	end

	initial begin
		M_ARESETN = 1'b1;
		repeat (5) @(posedge M_CLK);
		#1 M_ARESETN = 1'b0;
	end

	//////////////////////////////
	// Receiver and checker
	//////////////////////////////

	// Random ready, about three pops in four, unless held
	initial begin
		int unsigned seed;
		seed = 32'he6d4;
		void'($urandom(seed));
		i_m_ready = 1'b0;
		forever begin
			@(posedge M_CLK);
			#1;
			if (M_ARESETN || rx_hold)
				i_m_ready = 1'b0;
			else
				i_m_ready = ($urandom % 4) != 0;
		end
	end

	// Head entry and valid only move on the rising edge, so sample midway
	always @(negedge M_CLK) begin
		if (!M_ARESETN && o_m_valid && i_m_ready)
			check_entry(o_m_entry);
	end

	task automatic check_entry(input fifo_entry_t got);
		fifo_entry_t want;
		if (pop_count >= exp_q.size()) begin
			other_errors++;
			$display("Extra entry popped at %0t beyond the %0d expected", $time, exp_q.size());
		end else begin
			want = exp_q[pop_count];
			if (got.abort !== want.abort) begin
				mismatches++;
				$display("Mismatch at %0t: o_m_entry.abort expected %0b got %0b",
					$time, want.abort, got.abort);
			end
			// Marker beat fields are whatever the sender held, not packet data
			if (!want.abort && got.beat.last !== want.beat.last) begin
				mismatches++;
				$display("Mismatch at %0t: o_m_entry.beat.last expected %0b got %0b",
					$time, want.beat.last, got.beat.last);
			end
			if (!want.abort && got.beat.bytes !== want.beat.bytes) begin
				mismatches++;
				$display("Mismatch at %0t: o_m_entry.beat.bytes expected %0d got %0d",
					$time, want.beat.bytes, got.beat.bytes);
			end
			if (!want.abort && got.beat.data !== want.beat.data) begin
				mismatches++;
				$display("Mismatch at %0t: o_m_entry.beat.data expected %h got %h",
					$time, want.beat.data, got.beat.data);
			end
		end
		pop_count++;
	endtask

	//////////////////////////////
	// Vectors and sender
	//////////////////////////////

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		cmd_t        cmd;
		fifo_entry_t ent;
		logic [7:0]  op;
		int          flag;
		int          last;
		int          bytes;
		int          gap;
		logic [31:0] data;
		fd = $fopen("tb/pkt_cdc_vectors.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open tb/pkt_cdc_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				// Comment and blank lines fall through both branches
				if (n > 1 && line.getc(0) == "S") begin
					n = $sscanf(line, "S %c %d %d %h %d", op, last, bytes, data, gap);
					cmd.op         = op;
					cmd.gap        = gap;
					cmd.exp_before = exp_q.size();
					cmd.beat       = '{data: data, bytes: bytes[PKT_BW-1:0], last: last[0]};
					cmds.push_back(cmd);
				end else if (n > 1 && line.getc(0) == "E") begin
					n = $sscanf(line, "E %d %d %d %h", flag, last, bytes, data);
					ent.abort = flag[0];
					ent.beat  = '{data: data, bytes: bytes[PKT_BW-1:0], last: last[0]};
					exp_q.push_back(ent);
				end
			end
			$fclose(fd);
		end
	endtask

	// Hold one command on the sender port until it is taken
	task automatic send(input logic valid, input logic abort, input pkt_beat_t beat);
		int   waited;
		logic taken;
		waited    = 0;
		taken     = 1'b0;
		i_s_valid = valid;
		i_s_abort = abort;
		i_s_beat  = beat;
		while (!taken && !stalled) begin
			@(negedge S_CLK);
			// Lone abort strobe goes on the next edge
			taken = o_s_ready || !valid;
			if (!taken) begin
				waited++;
				if (waited > TIMEOUT) begin
					stalled = 1'b1;
					other_errors++;
					$display("Timeout at %0t: sender beat never accepted", $time);
				end
			end
			@(posedge S_CLK);
			#1;
		end
		i_s_valid = 1'b0;
		i_s_abort = 1'b0;
		i_s_beat  = '0;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge S_CLK);
			#1;
		end
	endtask

	task automatic wait_pops(input int n);
		int waited;
		waited = 0;
		while (pop_count < n && !stalled) begin
			@(posedge S_CLK);
			#1;
			waited++;
			if (waited > 4 * TIMEOUT) begin
				stalled = 1'b1;
				other_errors++;
				$display("Timeout at %0t: only %0d of %0d entries popped", $time, pop_count, n);
			end
		end
	endtask

	task automatic run_cmd(input cmd_t cmd);
		case (cmd.op)
			"B": send(1'b1, 1'b0, cmd.beat);
			"A": send(1'b0, 1'b1, '0);
			"P": begin
				// Drain what is queued, then stop reading
				wait_pops(cmd.exp_before);
				rx_hold = 1'b1;
				// Freed space reaches the write side within a few S_CLK cycles
				idle(6);
			end
			"G": rx_hold = 1'b0;
			"F": begin
				if (o_s_ready !== 1'b0) begin
					mismatches++;
					$display("Mismatch at %0t: o_s_ready expected 0 got %b", $time, o_s_ready);
				end
			end
			default: begin
				other_errors++;
				$display("Unknown command in the vectors file");
			end
		endcase
		idle(cmd.gap);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int waited;
		S_ARESETN    = 1'b1;
		i_s_valid    = 1'b0;
		i_s_abort    = 1'b0;
		i_s_beat     = '0;
		rx_hold      = 1'b0;
		stalled      = 1'b0;
		pop_count    = 0;
		mismatches   = 0;
		other_errors = 0;
		load_vectors();
		repeat (5) @(posedge S_CLK);
		#1 S_ARESETN = 1'b0;
		waited = 0;
		while (M_ARESETN && !stalled) begin
			@(posedge S_CLK);
			#1;
			waited++;
			if (waited > TIMEOUT) begin
				stalled = 1'b1;
				other_errors++;
				$display("Timeout: receiver reset never released");
			end
		end
		if (o_m_valid !== 1'b0) begin
			mismatches++;
			$display("Mismatch at %0t: o_m_valid expected 0 got %b", $time, o_m_valid);
		end
		if (o_s_ready !== 1'b1) begin
			mismatches++;
			$display("Mismatch at %0t: o_s_ready expected 1 got %b", $time, o_s_ready);
		end
		foreach (cmds[i]) begin
			if (!stalled)
				run_cmd(cmds[i]);
		end
		wait_pops(exp_q.size());
		// Short window to catch entries that should not exist
		repeat (10) @(posedge M_CLK);
		#1;
		if (pop_count != exp_q.size()) begin
			other_errors++;
			$display("Popped %0d entries but the vectors expect %0d", pop_count, exp_q.size());
		end
		if (o_m_valid !== 1'b0) begin
			mismatches++;
			$display("Mismatch at %0t: o_m_valid expected 0 got %b", $time, o_m_valid);
		end
		$display("Checked %0d entries: %0d mismatches, %0d other errors",
			pop_count, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* tb/pkt_cdc_vectors.txt */
# S op last bytes data gap : op B beat, A abort, P stop receiver, G resume, F expect full
# E abort last bytes data : expected entries in pop order, data in hex
# Clean packet
S B 0 4 a0000001 0
S B 1 2 a0000002 2
E 0 0 4 a0000001
E 0 1 2 a0000002
# Abort inside a packet, then a clean packet
S B 0 4 c0000001 1
S A 0 0 00000000 2
S B 1 3 c0000002 0
E 0 0 4 c0000001
E 1 0 0 00000000
E 0 1 3 c0000002
# Abort between packets leaves no entry
S A 0 0 00000000 1
S B 1 1 e0000001 0
E 0 1 1 e0000001
# Fill the FIFO with the receiver stopped, abort while full
S P 0 0 00000000 0
S B 0 4 f0000000 0
S B 0 4 f0000001 0
S B 0 4 f0000002 0
S B 0 4 f0000003 0
S B 0 4 f0000004 0
S B 0 4 f0000005 0
S B 0 4 f0000006 0
S B 0 4 f0000007 0
S B 0 4 f0000008 0
S B 0 4 f0000009 0
S B 0 4 f000000a 0
S B 0 4 f000000b 0
S B 0 4 f000000c 0
S B 0 4 f000000d 0
S B 0 4 f000000e 0
S B 0 4 f000000f 0
S F 0 0 00000000 2
S A 0 0 00000000 2
S G 0 0 00000000 0
S B 1 4 f1000001 0
E 0 0 4 f0000000
E 0 0 4 f0000001
E 0 0 4 f0000002
E 0 0 4 f0000003
E 0 0 4 f0000004
E 0 0 4 f0000005
E 0 0 4 f0000006
E 0 0 4 f0000007
E 0 0 4 f0000008
E 0 0 4 f0000009
E 0 0 4 f000000a
E 0 0 4 f000000b
E 0 0 4 f000000c
E 0 0 4 f000000d
E 0 0 4 f000000e
E 0 0 4 f000000f
E 1 0 0 00000000
E 0 1 4 f1000001

/* pkt_cdc.f */
logic/pkt_cdc_pkg.sv
logic/pkt_cdc_ram.sv
logic/pkt_cdc_wptr.sv
logic/pkt_cdc_rptr.sv
logic/pkt_cdc_ctrl.sv
logic/pkt_cdc_top.sv
tb/pkt_cdc_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module pkt_cdc_tb \
		-f pkt_cdc.f -Mdir obj_dir
	./obj_dir/Vpkt_cdc_tb | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
